/* logic/link_pkg.sv */
package link_pkg;

        // Width of the clocks-per-symbol field.
        localparam int RATE_W = 8;

        // Width of the symbol limit, the command argument and the report counters.
        localparam int COUNT_W = 16;

        // Length of the error-injection mask. The mask repeats every MASK_W symbols.
        localparam int MASK_W = 16;

        // Order of the PRBS. The polynomial is x^9 + x^5 + 1.
        localparam int PRBS_ORDER = 9;

        // The pacer needs at least two clocks per symbol.
        localparam logic [RATE_W-1:0] RATE_MIN = RATE_W'(2);
        localparam logic [RATE_W-1:0] RATE_DEFAULT = RATE_W'(4);

        // Command opcodes.
        localparam logic [1:0] OPC_SET_RATE = 2'd0;
        localparam logic [1:0] OPC_SET_MASK = 2'd1;
        localparam logic [1:0] OPC_RUN = 2'd2;
        localparam logic [1:0] OPC_READ = 2'd3;

        // One command word as it arrives with i_cmd_valid.
        typedef struct packed {
                logic [1:0]         opcode;
                logic [COUNT_W-1:0] arg;
        } link_cmd_t;

        // Configuration held by the decode stage.
        typedef struct packed {
                logic [RATE_W-1:0]  rate_div;
                logic [MASK_W-1:0]  err_mask;
                logic [COUNT_W-1:0] symbol_limit;
        } link_cfg_t;

        // Result returned on a read command.
        typedef struct packed {
                logic [COUNT_W-1:0] bit_count;
                logic [COUNT_W-1:0] err_count;
        } link_report_t;

endpackage

/* logic/link_cmd_decode.sv */
`timescale 1ns/1ps

module link_cmd_decode (
        input  logic                i_clock,
        input  logic                i_rst_n,
        input  logic                i_cmd_valid,
        input  link_pkg::link_cmd_t i_cmd,
        input  logic                i_busy,
        output link_pkg::link_cfg_t o_cfg,
        output logic                o_start,
        output logic                o_read
);

        logic accept;

        // A command is taken only when no run is active.
        // The start cycle itself also counts as busy, since the pacer raises its flag a cycle later.
        assign accept = i_cmd_valid && !i_busy && !o_start;

        always_ff @(posedge i_clock)
        begin
                if (!i_rst_n)
                begin
                        o_cfg.rate_div <= link_pkg::RATE_DEFAULT;
                        o_cfg.err_mask <= '0;
                        o_cfg.symbol_limit <= '0;
                        o_start <= 1'b0;
                        o_read <= 1'b0;
                end
                else
                begin
                        // Start and read are single-cycle strobes.
                        o_start <= 1'b0;
                        o_read <= 1'b0;
                        if (accept)
                        begin
                                case (i_cmd.opcode)
                                        link_pkg::OPC_SET_RATE:
                                        begin
                                                // Rates below the minimum are clamped.
                                                if (i_cmd.arg[link_pkg::RATE_W-1:0] < link_pkg::RATE_MIN)
                                                        o_cfg.rate_div <= link_pkg::RATE_MIN;
                                                else
                                                        o_cfg.rate_div <= i_cmd.arg[link_pkg::RATE_W-1:0];
                                        end
                                        link_pkg::OPC_SET_MASK:
                                                o_cfg.err_mask <= i_cmd.arg;
                                        link_pkg::OPC_RUN:
                                        begin
                                                o_cfg.symbol_limit <= i_cmd.arg;
                                                o_start <= 1'b1;
                                        end
                                        default:
                                                o_read <= 1'b1;
                                endcase
                        end
                end
        end

        // A read and a start never leave the decoder in the same cycle.
        a_start_read_exclusive: assert property (@(posedge i_clock) disable iff (!i_rst_n)
                !(o_start && o_read))
                else $error("start and read strobes overlap");

        // The pacer relies on at least two clocks per symbol.
        a_rate_floor: assert property (@(posedge i_clock) disable iff (!i_rst_n)
                o_cfg.rate_div >= link_pkg::RATE_MIN)
                else $error("rate_div fell below the minimum");

endmodule

/* logic/symbol_strobe_gen.sv */
`timescale 1ns/1ps

module symbol_strobe_gen (
        input  logic                         i_clock,
        input  logic                         i_rst_n,
        input  logic                         i_start,
        input  logic [link_pkg::RATE_W-1:0]  i_rate_div,
        input  logic [link_pkg::COUNT_W-1:0] i_symbol_limit,
        output logic                         o_strobe,
        output logic [link_pkg::COUNT_W-1:0] o_index,
        output logic                         o_busy
);

        logic [link_pkg::RATE_W-1:0]  scale_cnt;
        logic [link_pkg::COUNT_W-1:0] symbol_cnt;
        logic                         scale_wrap;
        logic                         limit_hit;
        logic                         last_strobe;

        // The scale counter runs from 0 to rate_div - 1 and wraps on the strobe.
        // After start it reaches the top on the rate_div-th clock.
        assign scale_wrap = (scale_cnt == i_rate_div - link_pkg::RATE_W'(1));

        // All requested symbols have been issued.
        assign limit_hit = (symbol_cnt == i_symbol_limit);

        assign o_strobe = o_busy && scale_wrap && !limit_hit;
        assign last_strobe = o_strobe && (symbol_cnt + link_pkg::COUNT_W'(1) == i_symbol_limit);

        // The symbol counter holds the number of the symbol that the next strobe carries.
        assign o_index = symbol_cnt;

        always_ff @(posedge i_clock)
        begin
                if (!i_rst_n)
                begin
                        o_busy <= 1'b0;
                        scale_cnt <= '0;
                        symbol_cnt <= '0;
                end
                else if (i_start)
                begin
                        o_busy <= 1'b1;
                        scale_cnt <= '0;
                        symbol_cnt <= '0;
                end
                else if (o_busy)
                begin
                        if (scale_wrap)
                                scale_cnt <= '0;
                        else
                                scale_cnt <= scale_cnt + link_pkg::RATE_W'(1);
                        if (o_strobe)
                                symbol_cnt <= symbol_cnt + link_pkg::COUNT_W'(1);
                        // Busy drops after the last strobe, or at once for an empty run.
                        if (limit_hit || last_strobe)
                                o_busy <= 1'b0;
                end
        end

        // With the decoder's rate clamp the strobes are always at least two clocks apart.
        a_strobe_spacing: assert property (@(posedge i_clock) disable iff (!i_rst_n)
                o_strobe |=> !o_strobe)
                else $error("symbol strobe high on two consecutive cycles");

endmodule

/* logic/prbs9_gen.sv */
`timescale 1ns/1ps

module prbs9_gen (
        input  logic i_clock,
        input  logic i_rst_n,
        input  logic i_start,
        input  logic i_step,
        output logic o_bit
);

        logic [link_pkg::PRBS_ORDER-1:0] lfsr;
        logic                            feedback;

        // Bit 0 holds the newest bit, so bits 8 and 4 are the bits sent 9 and 5 steps ago.
        assign feedback = lfsr[link_pkg::PRBS_ORDER-1] ^ lfsr[4];

        // The output is the bit that enters the register on this step.
        assign o_bit = feedback;

        always_ff @(posedge i_clock)
        begin
                // Every run starts from the all-ones seed.
                if (!i_rst_n || i_start)
                        lfsr <= '1;
                else if (i_step)
                        lfsr <= {lfsr[link_pkg::PRBS_ORDER-2:0], feedback};
        end

        // The all-zero state would lock the sequence up.
        a_lfsr_live: assert property (@(posedge i_clock) disable iff (!i_rst_n)
                lfsr != '0)
                else $error("PRBS9 register reached the all-zero state");

endmodule

/* logic/link_channel.sv */
`timescale 1ns/1ps

module link_channel (
        input  logic                         i_clock,
        input  logic                         i_rst_n,
        input  logic                         i_strobe,
        input  logic                         i_bit,
        input  logic [link_pkg::COUNT_W-1:0] i_index,
        input  logic [link_pkg::MASK_W-1:0]  i_err_mask,
        output logic                         o_rx_valid,
        output logic                         o_rx_bit
);

        logic flip;

        // The mask repeats every MASK_W symbols, so the low index bits pick the mask bit.
        assign flip = i_err_mask[i_index[$clog2(link_pkg::MASK_W)-1:0]];

        // The received bit is valid one clock after the strobe.
        always_ff @(posedge i_clock)
        begin
                if (!i_rst_n)
                        o_rx_valid <= 1'b0;
                else
                        o_rx_valid <= i_strobe;
        end

        // A selected mask bit inverts the symbol on its way through.
        always_ff @(posedge i_clock)
        begin
                if (i_strobe)
                        o_rx_bit <= i_bit ^ flip;
        end

endmodule

/* logic/ber_checker.sv */
`timescale 1ns/1ps

module ber_checker (
        input  logic                   i_clock,
        input  logic                   i_rst_n,
        input  logic                   i_start,
        input  logic                   i_rx_valid,
        input  logic                   i_rx_bit,
        input  logic                   i_read,
        output logic                   o_report_valid,
        output link_pkg::link_report_t o_report
);

        logic [link_pkg::PRBS_ORDER-1:0]         history;
        logic [$clog2(link_pkg::PRBS_ORDER+1)-1:0] fill_cnt;
        logic [link_pkg::COUNT_W-1:0]            bit_count;
        logic [link_pkg::COUNT_W-1:0]            err_count;
        logic                                    primed;
        logic                                    expected_bit;
        logic                                    bit_err;

        // Checking starts once the history holds a full PRBS9 window.
        assign primed = (fill_cnt == link_pkg::PRBS_ORDER);

        // History bit 0 is the previous bit, so bits 8 and 4 are 9 and 5 positions back.
        assign expected_bit = history[link_pkg::PRBS_ORDER-1] ^ history[4];
        assign bit_err = (i_rx_bit != expected_bit);

        always_ff @(posedge i_clock)
        begin
                if (!i_rst_n || i_start)
                begin
                        fill_cnt <= '0;
                        bit_count <= '0;
                        err_count <= '0;
                end
                else if (i_rx_valid)
                begin
                        if (!primed)
                                fill_cnt <= fill_cnt + 1'b1;
                        else
                        begin
                                // Both counters saturate at full scale.
                                if (bit_count != '1)
                                        bit_count <= bit_count + link_pkg::COUNT_W'(1);
                                if (bit_err && err_count != '1)
                                        err_count <= err_count + link_pkg::COUNT_W'(1);
                        end
                end
        end

        // The received stream itself seeds the reference, so the checker needs no known start.
        always_ff @(posedge i_clock)
        begin
                if (i_start)
                        history <= '0;
                else if (i_rx_valid)
                        history <= {history[link_pkg::PRBS_ORDER-2:0], i_rx_bit};
        end

        // The report is captured on read and flagged for one cycle.
        always_ff @(posedge i_clock)
        begin
                if (!i_rst_n)
                        o_report_valid <= 1'b0;
                else
                        o_report_valid <= i_read;
        end

        always_ff @(posedge i_clock)
        begin
                if (i_read)
                begin
                        o_report.bit_count <= bit_count;
                        o_report.err_count <= err_count;
                end
        end

endmodule

/* logic/prbs_link_top.sv */
`timescale 1ns/1ps

module prbs_link_top (
        input  logic                   i_clock,
        input  logic                   i_rst_n,
        input  logic                   i_cmd_valid,
        input  link_pkg::link_cmd_t    i_cmd,
        output logic                   o_busy,
        output logic                   o_report_valid,
        output link_pkg::link_report_t o_report
);

        link_pkg::link_cfg_t          cfg;
        logic                         start;
        logic                         read;
        logic                         strobe;
        logic [link_pkg::COUNT_W-1:0] index;
        logic                         tx_bit;
        logic                         rx_valid;
        logic                         rx_bit;

        // Decode stage. The pacer's busy flag blocks new commands during a run.
        link_cmd_decode u_decode (
                .i_clock     (i_clock),
                .i_rst_n     (i_rst_n),
                .i_cmd_valid (i_cmd_valid),
                .i_cmd       (i_cmd),
                .i_busy      (o_busy),
                .o_cfg       (cfg),
                .o_start     (start),
                .o_read      (read)
        );

        // Execute stage. The pacer drives the transmitter and the channel.
        symbol_strobe_gen u_pacer (
                .i_clock        (i_clock),
                .i_rst_n        (i_rst_n),
                .i_start        (start),
                .i_rate_div     (cfg.rate_div),
                .i_symbol_limit (cfg.symbol_limit),
                .o_strobe       (strobe),
                .o_index        (index),
                .o_busy         (o_busy)
        );

        prbs9_gen u_tx (
                .i_clock (i_clock),
                .i_rst_n (i_rst_n),
                .i_start (start),
                .i_step  (strobe),
                .o_bit   (tx_bit)
        );

        link_channel u_channel (
                .i_clock    (i_clock),
                .i_rst_n    (i_rst_n),
                .i_strobe   (strobe),
                .i_bit      (tx_bit),
                .i_index    (index),
                .i_err_mask (cfg.err_mask),
                .o_rx_valid (rx_valid),
                .o_rx_bit   (rx_bit)
        );

        // Result stage.
        ber_checker u_checker (
                .i_clock        (i_clock),
                .i_rst_n        (i_rst_n),
                .i_start        (start),
                .i_rx_valid     (rx_valid),
                .i_rx_bit       (rx_bit),
                .i_read         (read),
                .o_report_valid (o_report_valid),
                .o_report       (o_report)
        );

endmodule

/* tb/tb_prbs_link.sv */
`timescale 1ns/1ps

module tb_prbs_link;

        // Half of the 40 ns clock period.
        localparam int HALF_PERIOD = 20;
        localparam int RESET_CYCLES = 16;
        // Slack in clock cycles on top of the summed run lengths.
        localparam int MARGIN_PER_RECORD = 12;
        localparam int MARGIN_FIXED = 200;

        logic                   i_clock;
        logic                   i_rst_n;
        logic                   i_cmd_valid;
        link_pkg::link_cmd_t    i_cmd;
        logic                   o_busy;
        logic                   o_report_valid;
        link_pkg::link_report_t o_report;

        // Records of the data file, held in file order.
        byte rec_tag[$];
        int  rec_a[$];
        int  rec_b[$];

        // High only in the one cycle where a report is allowed to show.
        logic report_due;
        // Watchdog length in clock cycles, known once the data file is loaded.
        int   budget_cycles;
        logic budget_ready;

        // Count of falling edges seen so far.
        int   cycle_count;
        // Busy is expected high from busy_from up to, but not including, busy_until.
        int   busy_from;
        int   busy_until;
        // Clocks per symbol as the accepted commands have set it.
        int   model_rate;

        prbs_link_top dut (
                .i_clock        (i_clock),
                .i_rst_n        (i_rst_n),
                .i_cmd_valid    (i_cmd_valid),
                .i_cmd          (i_cmd),
                .o_busy         (o_busy),
                .o_report_valid (o_report_valid),
                .o_report       (o_report)
        );

        initial i_clock = 1'b0;
        always #HALF_PERIOD i_clock = ~i_clock;

        task automatic abort_run();
                $display("test failed");
                $fatal(1, "simulation stopped at the first error");
        endtask

        // A SET_RATE argument below two clocks per symbol is raised to two.
        function automatic int clamp_rate(input int arg);
                int low_byte;
                low_byte = arg % 256;
                if (low_byte < 2)
                        return 2;
                return low_byte;
        endfunction

        // A run holds busy for rate times length clocks, and an empty run for one clock.
        function automatic int busy_length(input int rate, input int symbols);
                if (symbols == 0)
                        return 1;
                return rate * symbols;
        endfunction

        function automatic logic run_active();
                return (cycle_count >= busy_from) && (cycle_count < busy_until);
        endfunction

        task automatic check_busy(input logic expected, input logic actual);
                if (actual !== expected)
                begin
                        $display("Error: time %0t o_busy expected %0b actual %0b",
                                 $time, expected, actual);
                        abort_run();
                end
        endtask

        // Every step of the main process lands on a falling edge, where outputs are stable.
        // A report that shows up outside its slot is caught here.
        // Busy is compared with the expected run window on every step.
        task automatic next_cycle();
                @(negedge i_clock);
                cycle_count++;
                if (o_report_valid === 1'b1 && !report_due)
                begin
                        $display("o_report_valid went high although no read was pending");
                        abort_run();
                end
                check_busy(run_active(), o_busy);
        endtask

        task automatic check_report(input link_pkg::link_report_t expected,
                                    input link_pkg::link_report_t actual);
                if (actual.bit_count !== expected.bit_count)
                begin
                        $display("Error: time %0t o_report.bit_count expected %0d actual %0d",
                                 $time, expected.bit_count, actual.bit_count);
                        abort_run();
                end
                if (actual.err_count !== expected.err_count)
                begin
                        $display("Error: time %0t o_report.err_count expected %0d actual %0d",
                                 $time, expected.err_count, actual.err_count);
                        abort_run();
                end
        endtask

        // The command is held for one cycle, then one idle cycle lets busy rise after a RUN.
        task automatic send_command(input logic [1:0] opcode,
                                    input logic [link_pkg::COUNT_W-1:0] arg);
                // Commands that meet a busy link are dropped and leave the model unchanged.
                if (!run_active())
                begin
                        if (opcode == link_pkg::OPC_SET_RATE)
                                model_rate = clamp_rate(int'(arg));
                        if (opcode == link_pkg::OPC_RUN)
                        begin
                                // Busy rises two falling edges after the command is driven.
                                busy_from = cycle_count + 2;
                                busy_until = busy_from + busy_length(model_rate, int'(arg));
                        end
                end
                i_cmd_valid = 1'b1;
                i_cmd.opcode = opcode;
                i_cmd.arg = arg;
                next_cycle();
                i_cmd_valid = 1'b0;
                i_cmd = '0;
                next_cycle();
        endtask

        task automatic wait_idle();
                while (o_busy !== 1'b0)
                        next_cycle();
        endtask

        // The report must appear exactly two cycles after the READ strobe, and not before.
        task automatic read_and_check(input link_pkg::link_report_t expected);
                i_cmd_valid = 1'b1;
                i_cmd.opcode = link_pkg::OPC_READ;
                i_cmd.arg = '0;
                next_cycle();
                i_cmd_valid = 1'b0;
                i_cmd = '0;
                report_due = 1'b1;
                next_cycle();
                report_due = 1'b0;
                if (o_report_valid !== 1'b1)
                begin
                        $display("o_report_valid did not arrive two cycles after the read");
                        abort_run();
                end
                check_report(expected, o_report);
        endtask

        initial
        begin
                int                     fd;
                int                     code;
                int                     a;
                int                     b;
                int                     rate;
                int                     run_cycles;
                string                  line;
                link_pkg::link_report_t expected;

                i_rst_n = 1'b0;
                i_cmd_valid = 1'b0;
                i_cmd = '0;
                report_due = 1'b0;
                budget_ready = 1'b0;
                budget_cycles = 0;
                cycle_count = 0;
                busy_from = 0;
                busy_until = 0;
                model_rate = 4;

                fd = $fopen("tb/link_input.txt", "r");
                if (fd == 0)
                begin
                        $display("the data file tb/link_input.txt could not be opened");
                        abort_run();
                end

                // The budget tracks rate_div as the commands set it, from its reset value of 4.
                rate = 4;
                run_cycles = 0;
                while (!$feof(fd))
                begin
                        line = "";
                        code = $fgets(line, fd);
                        if (code == 0 || line.len() == 0 || line[0] == "#" || line[0] == "\n")
                                continue;
                        a = 0;
                        b = 0;
                        case (line[0])
                                "C":
                                begin
                                        code = $sscanf(line, "C %d %h", a, b);
                                        if (a == int'(link_pkg::OPC_SET_RATE))
                                                rate = clamp_rate(b);
                                        if (a == int'(link_pkg::OPC_RUN))
                                                run_cycles += busy_length(rate, b);
                                end
                                "R":
                                        code = $sscanf(line, "R %d %d", a, b);
                                "W":
                                        code = 2;
                                default:
                                        code = 0;
                        endcase
                        if (code != 2)
                        begin
                                $display("the data file holds a record that cannot be read: %s",
                                         line);
                                abort_run();
                        end
                        rec_tag.push_back(line[0]);
                        rec_a.push_back(a);
                        rec_b.push_back(b);
                end
                $fclose(fd);

                budget_cycles = run_cycles + MARGIN_PER_RECORD * rec_tag.size()
                                + RESET_CYCLES + MARGIN_FIXED;
                budget_ready = 1'b1;

                repeat (RESET_CYCLES)
                        next_cycle();
                i_rst_n = 1'b1;
                next_cycle();
                next_cycle();

                foreach (rec_tag[i])
                begin
                        a = rec_a[i];
                        b = rec_b[i];
                        case (rec_tag[i])
                                "C":
                                        send_command(a[1:0], b[link_pkg::COUNT_W-1:0]);
                                "R":
                                begin
                                        expected.bit_count = a[link_pkg::COUNT_W-1:0];
                                        expected.err_count = b[link_pkg::COUNT_W-1:0];
                                        read_and_check(expected);
                                end
                                default:
                                        wait_idle();
                        endcase
                end

                $display("test passed");
                $finish;
        end

        // The watchdog starts counting once the run lengths in the data file are known.
        initial
        begin
                wait (budget_ready === 1'b1);
                repeat (budget_cycles) @(posedge i_clock);
                $display("the run timed out waiting for the link");
                abort_run();
        end

endmodule

/* tb/link_input.txt */
# C opcode arg_hex: opcode 0 set rate, 1 set mask, 2 run. W waits until the link is idle.
# R bits errs issues a read and expects that report two cycles later.
C 0 0004
C 1 0000
C 2 0064
W
R 91 0
C 1 0001
C 2 0064
W
R 91 17
C 0 0001
C 2 0064
W
R 91 17
C 0 0007
C 2 0064
W
R 91 17
R 91 17
C 2 0005
C 1 ffff
W
R 0 0
C 2 0064
W
R 91 17

/* vlog.f */
logic/link_pkg.sv
logic/link_cmd_decode.sv
logic/symbol_strobe_gen.sv
logic/prbs9_gen.sv
logic/link_channel.sv
logic/ber_checker.sv
logic/prbs_link_top.sv
tb/tb_prbs_link.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_prbs_link
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
